// File: common/bt_types_pkg.sv
package bt_types_pkg;

	// Bridge sizing
	localparam int stream_count = 4;
	localparam int stream_fifo_depth = 8;
	localparam int at_fifo_depth = 16;
	localparam int rsp_fifo_depth = 16;
	localparam int rest_cycles = 12;

	// Controller states, same codes as the board build
	typedef enum logic [3:0] {
		st_idle             = 4'b0000,
		st_wait_switch      = 4'b0001,
		st_load_at          = 4'b0010,
		st_rest_at          = 4'b0011,
		st_release          = 4'b0100,
		st_load_tx          = 4'b0101,
		st_begin_tx         = 4'b0110,
		st_rest_tx          = 4'b0111,
		st_receive_rsp      = 4'b1000,
		st_wait_rsp_request = 4'b1101,
		st_read_rsp         = 4'b1110,
		st_rest_rsp         = 4'b1111
	} bridge_state_e;

	// Host control levels
	typedef struct packed {
		logic want_at;
		logic access_streams;
		logic user_data_loaded;
		logic user_knows_stored;
		logic user_data_done;
		logic access_rsp;
		logic user_received_data;
		logic finished_with_rsp;
	} host_ctrl_t;

	typedef struct packed {
		bridge_state_e state;
		logic data_stored_for_user;
		logic data_ready_for_user;
	} host_status_t;

	// One sensor byte stream, valid is a strobe
	typedef struct packed {
		logic valid;
		logic [7:0] data;
	} stream_in_t;

endpackage

// File: common/uart_pkg.sv
package uart_pkg;

	// Start, eight data bits, stop
	localparam int uart_frame_bits = 10;

	// Upper nibble of a byte from the phone app that carries a stream mask
	localparam logic [3:0] app_cmd_tag = 4'hA;

	// Last byte of a module reply
	localparam logic [7:0] rsp_terminator = 8'h0D;

	typedef struct packed {
		logic valid;
		logic [7:0] data;
	} rx_byte_t;

endpackage

// File: design/byte_fifo.sv
module byte_fifo #(
	parameter int depth = 16
) (
	input  logic clock,
	input  logic reset,
	input  logic push,
	input  logic pop,
	input  logic [7:0] din,
	output logic [7:0] dout,
	output logic [$clog2(depth + 1) - 1:0] count,
	output logic empty,
	output logic full
);
	localparam int addr_bits = $clog2(depth);
	localparam int count_bits = $clog2(depth + 1);

	logic [7:0] mem [depth];
	logic [addr_bits - 1:0] wr_ptr;
	logic [addr_bits - 1:0] rd_ptr;
	logic do_push;
	logic do_pop;

	function automatic logic [addr_bits - 1:0] advance(input logic [addr_bits - 1:0] ptr);
		if (ptr == addr_bits'(depth - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign empty = (count == '0);
	assign full = (count == count_bits'(depth));
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	// Head byte is visible without a read
	assign dout = mem[rd_ptr];

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= advance(wr_ptr);
			if (do_pop)
				rd_ptr <= advance(rd_ptr);
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (do_push)
			mem[wr_ptr] <= din;
	end

endmodule

// File: design/stream_switch.sv
module stream_switch (
	input  logic clock,
	input  logic reset,
	input  logic cmd_valid,
	input  logic [bt_types_pkg::stream_count - 1:0] cmd_mask,
	input  logic [bt_types_pkg::stream_count - 1:0] empties,
	input  logic select_req,
	output logic [$clog2(bt_types_pkg::stream_count) - 1:0] select,
	output logic select_ready,
	output logic data_pending
);
	import bt_types_pkg::*;

	localparam int sel_bits = $clog2(stream_count);

	logic [stream_count - 1:0] enable_mask;
	logic [stream_count - 1:0] candidates;
	logic [sel_bits - 1:0] next_pick;
	logic [sel_bits - 1:0] probe;

	// Streams the app asked for that hold at least one byte
	assign candidates = enable_mask & ~empties;
	assign data_pending = |candidates;

	// Walk from farthest to nearest after the last served stream,
	// so the nearest candidate wins
	always_comb
	begin
		next_pick = select;
		probe = select;
		for (int i = stream_count; i >= 1; i--)
		begin
			probe = sel_bits'((int'(select) + i) % stream_count);
			if (candidates[probe])
				next_pick = probe;
		end
	end

	// select doubles as the last served pointer
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			enable_mask <= '0;
			select <= sel_bits'(stream_count - 1);
			select_ready <= 1'b0;
		end
		else
		begin
			if (cmd_valid)
				enable_mask <= cmd_mask;
			select_ready <= select_req;
			if (select_req)
				select <= next_pick;
		end
	end

endmodule

// File: bridge_ctrl/bridge_ctrl.sv
module bridge_ctrl (
	input  logic clock,
	input  logic reset,
	input  bt_types_pkg::host_ctrl_t host,
	input  logic at_empty,
	input  logic data_pending,
	input  logic select_ready,
	input  logic [$clog2(bt_types_pkg::stream_count) - 1:0] select,
	input  logic [bt_types_pkg::stream_count - 1:0][7:0] stream_heads,
	input  logic [7:0] at_head,
	input  logic tx_done,
	input  logic rsp_done,
	output bt_types_pkg::host_status_t status,
	output logic at_push,
	output logic at_pop,
	output logic [bt_types_pkg::stream_count - 1:0] stream_pop,
	output logic rsp_pop,
	output logic select_req,
	output logic capture_rsp,
	output logic tx_start,
	output logic [7:0] tx_data
);
	import bt_types_pkg::*;

	localparam int rest_bits = $clog2(rest_cycles);

	bridge_state_e state;
	bridge_state_e next_state;
	logic [rest_bits - 1:0] rest_cnt;
	logic rest_done;
	logic more_to_send;
	logic [7:0] tx_hold;

	assign rest_done = (rest_cnt == rest_bits'(rest_cycles - 1));

	// AT mode drains the AT FIFO, data mode drains the enabled streams
	assign more_to_send = host.want_at ? !at_empty : data_pending;

	always_comb
	begin
		case (state)
			st_idle:
			begin
				if (host.want_at)
					next_state = host.user_data_loaded ? st_load_at : st_idle;
				else if (host.access_streams && data_pending)
					next_state = st_wait_switch;
				else
					next_state = st_idle;
			end
			st_load_at:
				next_state = st_rest_at;
			st_rest_at:
			begin
				if (!host.user_knows_stored)
					next_state = st_rest_at;
				else if (host.user_data_done)
					next_state = st_wait_switch;
				else
					next_state = st_idle;
			end
			st_wait_switch:
				next_state = select_ready ? st_release : st_wait_switch;
			st_release:
				next_state = st_load_tx;
			st_load_tx:
				next_state = st_begin_tx;
			st_begin_tx:
				next_state = tx_done ? st_rest_tx : st_begin_tx;
			st_rest_tx:
			begin
				if (!rest_done)
					next_state = st_rest_tx;
				else if (more_to_send)
					next_state = st_wait_switch;
				else if (host.want_at)
					next_state = st_receive_rsp;
				else
					next_state = st_idle;
			end
			st_receive_rsp:
				next_state = rsp_done ? st_wait_rsp_request : st_receive_rsp;
			st_wait_rsp_request:
				next_state = host.access_rsp ? st_read_rsp : st_wait_rsp_request;
			st_read_rsp:
				next_state = st_rest_rsp;
			st_rest_rsp:
			begin
				if (!host.user_received_data)
					next_state = st_rest_rsp;
				else if (host.finished_with_rsp)
					next_state = st_idle;
				else
					next_state = st_wait_rsp_request;
			end
			default:
				next_state = st_idle;
		endcase
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state <= st_idle;
			rest_cnt <= '0;
			tx_start <= 1'b0;
		end
		else
		begin
			state <= next_state;
			// load_tx always leads to begin_tx, so start lands on its first cycle
			tx_start <= (state == st_load_tx);
			if (state == st_rest_tx)
				rest_cnt <= rest_cnt + 1'b1;
			else
				rest_cnt <= '0;
		end
	end

	// Capture the head in the same cycle that pops it
	always_ff @(posedge clock)
	begin
		if (state == st_release)
			tx_hold <= host.want_at ? at_head : stream_heads[select];
	end

	always_comb
	begin
		stream_pop = '0;
		if (state == st_release && !host.want_at)
			stream_pop[select] = 1'b1;
	end

	assign at_push = (state == st_load_at);
	assign at_pop = (state == st_release) && host.want_at;
	assign rsp_pop = (state == st_read_rsp);
	// Request on the first wait_switch cycle only
	assign select_req = (state == st_wait_switch) && !select_ready;
	assign capture_rsp = (state == st_receive_rsp);
	assign tx_data = tx_hold;

	assign status.state = state;
	assign status.data_stored_for_user = (state == st_rest_at);
	assign status.data_ready_for_user = (state == st_rest_rsp);

endmodule

// File: uart/uart_tx.sv
module uart_tx (
	input  logic clock,
	input  logic reset,
	input  logic start,
	input  logic [9:0] cycles_per_bit,
	input  logic [7:0] tx_data,
	output logic txd,
	output logic tx_done,
	output logic busy
);
	import uart_pkg::*;

	logic [9:0] cycle_cnt;
	logic [3:0] bit_cnt;
	logic [8:0] shift;
	logic bit_end;

	assign bit_end = (cycle_cnt == cycles_per_bit - 10'd1);

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			txd <= 1'b1;
			busy <= 1'b0;
			tx_done <= 1'b0;
			cycle_cnt <= '0;
			bit_cnt <= '0;
		end
		else
		begin
			tx_done <= 1'b0;
			if (!busy)
			begin
				if (start)
				begin
					// Start bit goes out right away
					busy <= 1'b1;
					txd <= 1'b0;
					cycle_cnt <= '0;
					bit_cnt <= '0;
				end
			end
			else if (bit_end)
			begin
				cycle_cnt <= '0;
				if (bit_cnt == 4'(uart_frame_bits - 1))
				begin
					busy <= 1'b0;
					tx_done <= 1'b1;
				end
				else
				begin
					txd <= shift[0];
					bit_cnt <= bit_cnt + 4'd1;
				end
			end
			else
				cycle_cnt <= cycle_cnt + 10'd1;
		end
	end

	// Data LSB first, stop bit on top
	always_ff @(posedge clock)
	begin
		if (start && !busy)
			shift <= {1'b1, tx_data};
		else if (busy && bit_end)
			shift <= {1'b1, shift[8:1]};
	end

endmodule

// File: uart/uart_rx.sv
module uart_rx (
	input  logic clock,
	input  logic reset,
	input  logic rxd,
	input  logic [9:0] cycles_per_bit,
	input  logic capture_rsp,
	output logic cmd_valid,
	output logic [3:0] cmd_mask,
	output uart_pkg::rx_byte_t rsp,
	output logic rsp_done
);
	import uart_pkg::*;

	typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} rx_state_e;

	rx_state_e state;
	logic rxd_meta;
	logic rxd_sync;
	logic [9:0] cycle_cnt;
	logic [2:0] bit_cnt;
	logic [7:0] shift;
	logic [7:0] rsp_data;
	logic rsp_valid;
	logic half_end;
	logic bit_end;
	logic frame_ok;
	logic is_cmd;

	assign half_end = (cycle_cnt == (cycles_per_bit >> 1) - 10'd1);
	assign bit_end = (cycle_cnt == cycles_per_bit - 10'd1);
	// Stop bit sampled high
	assign frame_ok = (state == rx_stop) && bit_end && rxd_sync;
	assign is_cmd = (shift[7:4] == app_cmd_tag);

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state <= rx_idle;
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			cycle_cnt <= '0;
			bit_cnt <= '0;
			cmd_valid <= 1'b0;
			rsp_valid <= 1'b0;
			rsp_done <= 1'b0;
		end
		else
		begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			cmd_valid <= frame_ok && is_cmd;
			rsp_valid <= frame_ok && !is_cmd && capture_rsp;
			rsp_done <= frame_ok && !is_cmd && capture_rsp && (shift == rsp_terminator);
			cycle_cnt <= cycle_cnt + 10'd1;
			case (state)
				rx_idle:
				begin
					cycle_cnt <= '0;
					if (!rxd_sync)
						state <= rx_start;
				end
				rx_start:
				begin
					// Recheck the start bit at mid-period to reject glitches
					if (half_end)
					begin
						cycle_cnt <= '0;
						bit_cnt <= '0;
						state <= rxd_sync ? rx_idle : rx_data;
					end
				end
				rx_data:
				begin
					if (bit_end)
					begin
						cycle_cnt <= '0;
						bit_cnt <= bit_cnt + 3'd1;
						if (bit_cnt == 3'd7)
							state <= rx_stop;
					end
				end
				default:
				begin
					if (bit_end)
					begin
						cycle_cnt <= '0;
						state <= rx_idle;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (state == rx_data && bit_end)
			shift <= {rxd_sync, shift[7:1]};
		if (frame_ok && is_cmd)
			cmd_mask <= shift[3:0];
		if (frame_ok && !is_cmd)
			rsp_data <= shift;
	end

	assign rsp.valid = rsp_valid;
	assign rsp.data = rsp_data;

endmodule

// File: design/bt_bridge.sv
module bt_bridge (
	input  logic clock,
	input  logic reset,
	input  bt_types_pkg::host_ctrl_t host_ctrl,
	input  logic [7:0] at_byte,
	input  logic [9:0] cycles_per_bit,
	input  bt_types_pkg::stream_in_t [bt_types_pkg::stream_count - 1:0] streams,
	output bt_types_pkg::host_status_t status,
	output logic [7:0] rsp_byte,
	output logic [$clog2(bt_types_pkg::rsp_fifo_depth + 1) - 1:0] rsp_count,
	output logic txd,
	input  logic rxd
);
	import bt_types_pkg::*;
	import uart_pkg::*;

	logic [stream_count - 1:0] stream_empties;
	logic [stream_count - 1:0] stream_pop;
	logic [stream_count - 1:0][7:0] stream_heads;
	logic [$clog2(stream_count) - 1:0] select;
	logic select_req;
	logic select_ready;
	logic data_pending;
	logic at_push;
	logic at_pop;
	logic at_empty;
	logic [7:0] at_head;
	logic rsp_pop;
	rx_byte_t rsp;
	logic rsp_done;
	logic cmd_valid;
	logic [stream_count - 1:0] cmd_mask;
	logic capture_rsp;
	logic tx_start;
	logic [7:0] tx_data;
	logic tx_done;

	// Sensor streams, a full FIFO drops the strobe
	for (genvar i = 0; i < stream_count; i++)
	begin : g_stream
		byte_fifo #(
			.depth(stream_fifo_depth)
		) stream_fifo_i (
			.clock(clock),
			.reset(reset),
			.push(streams[i].valid),
			.pop(stream_pop[i]),
			.din(streams[i].data),
			.dout(stream_heads[i]),
			.count(),
			.empty(stream_empties[i]),
			.full()
		);
	end

	byte_fifo #(
		.depth(at_fifo_depth)
	) at_fifo_i (
		.clock(clock),
		.reset(reset),
		.push(at_push),
		.pop(at_pop),
		.din(at_byte),
		.dout(at_head),
		.count(),
		.empty(at_empty),
		.full()
	);

	// Module replies, read by the host
	byte_fifo #(
		.depth(rsp_fifo_depth)
	) rsp_fifo_i (
		.clock(clock),
		.reset(reset),
		.push(rsp.valid),
		.pop(rsp_pop),
		.din(rsp.data),
		.dout(rsp_byte),
		.count(rsp_count),
		.empty(),
		.full()
	);

	stream_switch switch_i (
		.clock(clock),
		.reset(reset),
		.cmd_valid(cmd_valid),
		.cmd_mask(cmd_mask),
		.empties(stream_empties),
		.select_req(select_req),
		.select(select),
		.select_ready(select_ready),
		.data_pending(data_pending)
	);

	bridge_ctrl ctrl_i (
		.clock(clock),
		.reset(reset),
		.host(host_ctrl),
		.at_empty(at_empty),
		.data_pending(data_pending),
		.select_ready(select_ready),
		.select(select),
		.stream_heads(stream_heads),
		.at_head(at_head),
		.tx_done(tx_done),
		.rsp_done(rsp_done),
		.status(status),
		.at_push(at_push),
		.at_pop(at_pop),
		.stream_pop(stream_pop),
		.rsp_pop(rsp_pop),
		.select_req(select_req),
		.capture_rsp(capture_rsp),
		.tx_start(tx_start),
		.tx_data(tx_data)
	);

	uart_tx tx_i (
		.clock(clock),
		.reset(reset),
		.start(tx_start),
		.cycles_per_bit(cycles_per_bit),
		.tx_data(tx_data),
		.txd(txd),
		.tx_done(tx_done),
		.busy()
	);

	uart_rx rx_i (
		.clock(clock),
		.reset(reset),
		.rxd(rxd),
		.cycles_per_bit(cycles_per_bit),
		.capture_rsp(capture_rsp),
		.cmd_valid(cmd_valid),
		.cmd_mask(cmd_mask),
		.rsp(rsp),
		.rsp_done(rsp_done)
	);

endmodule

// File: verif/bt_bridge_asserts.sv
module bt_bridge_asserts (
	input  logic clock,
	input  logic reset,
	input  logic tx_start,
	input  logic at_pop,
	input  logic [bt_types_pkg::stream_count - 1:0] stream_pop,
	input  logic rsp_pop,
	input  bt_types_pkg::host_status_t status
);
	timeunit 1ns;
	timeprecision 100ps;

	import bt_types_pkg::*;

	// Transmitter start is a single-cycle pulse
	start_pulse: assert property (@(posedge clock) disable iff (reset)
		tx_start |=> !tx_start)
		else $error("tx_start held for more than one cycle");

	// Only one FIFO is popped in any cycle
	single_pop: assert property (@(posedge clock) disable iff (reset)
		$onehot0({at_pop, stream_pop, rsp_pop}))
		else $error("more than one FIFO pop in the same cycle");

	// Ready follows a response pop and holds until the host acknowledges
	ready_in_rest: assert property (@(posedge clock) disable iff (reset)
		status.data_ready_for_user |-> $past(rsp_pop) || $past(status.data_ready_for_user))
		else $error("data_ready_for_user without a preceding response pop");

endmodule

bind bridge_ctrl bt_bridge_asserts asserts_i (
	.clock(clock),
	.reset(reset),
	.tx_start(tx_start),
	.at_pop(at_pop),
	.stream_pop(stream_pop),
	.rsp_pop(rsp_pop),
	.status(status)
);

// File: verif/bt_bridge_tb.sv
module bt_bridge_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import bt_types_pkg::*;
	import uart_pkg::*;

	localparam int bit_period = 4;
	// About 32 frames with their rest gaps over all tests, tenfold margin
	localparam int byte_cycles = uart_frame_bits * bit_period + rest_cycles + 8;
	localparam int timeout_cycles = 32 * byte_cycles * 10;

	logic clock;
	logic reset;
	host_ctrl_t host_ctrl;
	logic [7:0] at_byte;
	logic [9:0] cycles_per_bit;
	stream_in_t [stream_count - 1:0] streams;
	logic rxd;
	host_status_t status;
	logic [7:0] rsp_byte;
	logic [$clog2(rsp_fifo_depth + 1) - 1:0] rsp_count;
	logic txd;

	logic [7:0] lfsr_state = 8'd63;
	int cycle_count = 0;
	// Expected contents of each stream FIFO
	logic [7:0] model_q [stream_count][$];
	logic [stream_count - 1:0] enabled = '0;
	int last_served = stream_count - 1;

	bt_bridge dut_i (
		.clock(clock),
		.reset(reset),
		.host_ctrl(host_ctrl),
		.at_byte(at_byte),
		.cycles_per_bit(cycles_per_bit),
		.streams(streams),
		.status(status),
		.rsp_byte(rsp_byte),
		.rsp_count(rsp_count),
		.txd(txd),
		.rxd(rxd)
	);

	initial
	begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	always @(posedge clock)
	begin
		cycle_count++;
		if (cycle_count >= timeout_cycles)
			report_failure($sformatf("timeout after %0d cycles, the DUT stopped responding",
				cycle_count));
	end

	// Galois form of x^8 + x^6 + x^5 + x^4 + 1
	function automatic logic [7:0] lfsr_next(input logic [7:0] s);
		if (s[0])
			return (s >> 1) ^ 8'hB8;
		return s >> 1;
	endfunction

	function automatic logic [7:0] random_byte();
		logic [7:0] b;
		for (int i = 0; i < 8; i++)
		begin
			b[i] = lfsr_state[0];
			lfsr_state = lfsr_next(lfsr_state);
		end
		return b;
	endfunction

	task automatic compare_bit(input string name, input logic actual, input logic expected);
		if (actual !== expected)
			report_failure($sformatf("mismatch %s: got %h expected %h", name, actual, expected));
	endtask

	task automatic compare_byte(input string name, input logic [7:0] actual,
		input logic [7:0] expected);
		if (actual !== expected)
			report_failure($sformatf("mismatch %s: got %h expected %h", name, actual, expected));
	endtask

	task automatic compare_status(input host_status_t actual, input host_status_t expected);
		if (actual !== expected)
			report_failure($sformatf("mismatch status: got %h expected %h", actual, expected));
	endtask

	task automatic compare_count(input string name, input int actual, input int expected);
		if (actual != expected)
			report_failure($sformatf("mismatch %s: got %h expected %h", name, actual, expected));
	endtask

	task automatic wait_state(input bridge_state_e s);
		@(negedge clock);
		while (status.state != s)
			@(negedge clock);
	endtask

	// Samples txd near the middle of each bit, called on the first low cycle
	task automatic sample_frame(output logic [7:0] b);
		repeat (bit_period / 2) @(negedge clock);
		if (txd !== 1'b0)
			report_failure("start bit on txd did not last half a bit");
		for (int i = 0; i < 8; i++)
		begin
			repeat (bit_period) @(negedge clock);
			b[i] = txd;
		end
		repeat (bit_period) @(negedge clock);
		if (txd !== 1'b1)
			report_failure("stop bit on txd was low");
	endtask

	task automatic receive_frame(output logic [7:0] b);
		@(negedge clock);
		while (txd !== 1'b0)
			@(negedge clock);
		sample_frame(b);
	endtask

	// Next frame on txd, or none once the bridge is back in idle
	task automatic receive_or_idle(output logic [7:0] b, output logic found);
		found = 1'b0;
		b = '0;
		@(negedge clock);
		while (txd !== 1'b0 && status.state != st_idle)
			@(negedge clock);
		if (txd === 1'b0)
		begin
			found = 1'b1;
			sample_frame(b);
		end
	endtask

	// One 8N1 frame on rxd plus one idle bit
	task automatic send_rx_byte(input logic [7:0] b);
		@(negedge clock);
		rxd = 1'b0;
		repeat (bit_period) @(negedge clock);
		for (int i = 0; i < 8; i++)
		begin
			rxd = b[i];
			repeat (bit_period) @(negedge clock);
		end
		rxd = 1'b1;
		repeat (2 * bit_period) @(negedge clock);
	endtask

	task automatic load_at_byte(input logic [7:0] b, input logic last);
		@(negedge clock);
		at_byte = b;
		host_ctrl.user_data_loaded = 1'b1;
		wait_state(st_rest_at);
		compare_status(status, host_status_t'{st_rest_at, 1'b1, 1'b0});
		host_ctrl.user_data_loaded = 1'b0;
		host_ctrl.user_knows_stored = 1'b1;
		host_ctrl.user_data_done = last;
		@(negedge clock);
		host_ctrl.user_knows_stored = 1'b0;
		host_ctrl.user_data_done = 1'b0;
	endtask

	// A full FIFO drops the byte
	task automatic push_stream(input int idx, input logic [7:0] b);
		@(negedge clock);
		streams[idx].valid = 1'b1;
		streams[idx].data = b;
		if (model_q[idx].size() < stream_fifo_depth)
			model_q[idx].push_back(b);
		@(negedge clock);
		streams[idx].valid = 1'b0;
	endtask

	// Round robin over enabled, non-empty streams after the last served one
	function automatic int next_stream();
		int idx;
		for (int i = 1; i <= stream_count; i++)
		begin
			idx = (last_served + i) % stream_count;
			if (enabled[idx] && model_q[idx].size() > 0)
				return idx;
		end
		return -1;
	endfunction

	task automatic expect_idle_line(input int cycles);
		repeat (cycles)
		begin
			@(negedge clock);
			if (txd !== 1'b1 || status.state != st_idle)
				report_failure("the bridge sent more than the enabled streams held");
		end
	endtask

	task automatic drain_streams();
		logic [7:0] got;
		logic found;
		int pick;
		int sent;
		int total;
		sent = 0;
		total = 0;
		for (int s = 0; s < stream_count; s++)
			if (enabled[s])
				total += model_q[s].size();
		@(negedge clock);
		host_ctrl.access_streams = 1'b1;
		receive_or_idle(got, found);
		while (found)
		begin
			pick = next_stream();
			if (pick < 0)
				report_failure("the bridge sent a byte that no enabled stream held");
			else
			begin
				compare_byte($sformatf("txd stream %0d byte", pick), got,
					model_q[pick].pop_front());
				last_served = pick;
			end
			sent++;
			receive_or_idle(got, found);
		end
		// Streams stay accessible so a leftover byte would restart the bridge
		expect_idle_line(2 * uart_frame_bits * bit_period);
		host_ctrl.access_streams = 1'b0;
		compare_count("transmitted bytes", sent, total);
	endtask

	task automatic check_reset_values();
		@(negedge clock);
		compare_bit("txd", txd, 1'b1);
		compare_status(status, host_status_t'{st_idle, 1'b0, 1'b0});
	endtask

	task automatic send_at_command();
		logic [7:0] cmd [5];
		logic [7:0] got;
		@(negedge clock);
		host_ctrl.want_at = 1'b1;
		for (int i = 0; i < 5; i++)
		begin
			cmd[i] = random_byte();
			load_at_byte(cmd[i], i == 4);
		end
		for (int i = 0; i < 5; i++)
		begin
			receive_frame(got);
			compare_byte("txd AT byte", got, cmd[i]);
		end
	endtask

	task automatic read_at_response();
		logic [7:0] reply [4];
		// Kept clear of the app command tag and the terminator
		for (int i = 0; i < 3; i++)
			reply[i] = 8'h40 | (random_byte() & 8'h3F);
		reply[3] = rsp_terminator;
		wait_state(st_receive_rsp);
		for (int i = 0; i < 4; i++)
			send_rx_byte(reply[i]);
		wait_state(st_wait_rsp_request);
		compare_count("rsp_count", int'(rsp_count), 4);
		for (int i = 0; i < 4; i++)
		begin
			compare_byte("rsp_byte", rsp_byte, reply[i]);
			host_ctrl.access_rsp = 1'b1;
			wait_state(st_rest_rsp);
			compare_status(status, host_status_t'{st_rest_rsp, 1'b0, 1'b1});
			host_ctrl.access_rsp = 1'b0;
			host_ctrl.user_received_data = 1'b1;
			host_ctrl.finished_with_rsp = (i == 3);
			@(negedge clock);
			host_ctrl.user_received_data = 1'b0;
			host_ctrl.finished_with_rsp = 1'b0;
		end
		compare_status(status, host_status_t'{st_idle, 1'b0, 1'b0});
		compare_count("rsp_count after read", int'(rsp_count), 0);
		host_ctrl.want_at = 1'b0;
	endtask

	task automatic select_streams();
		send_rx_byte(8'hA5);
		enabled = 4'b0101;
		for (int s = 0; s < stream_count; s++)
			for (int n = 0; n < ((s == 0) ? 3 : 2); n++)
				push_stream(s, random_byte());
		drain_streams();
	endtask

	// Stream 1 still holds its bytes from the selection test
	task automatic overflow_stream();
		send_rx_byte(8'hA2);
		enabled = 4'b0010;
		drain_streams();
		for (int n = 0; n < 10; n++)
			push_stream(1, random_byte());
		drain_streams();
	endtask

	initial
	begin
		reset = 1'b1;
		host_ctrl = '0;
		at_byte = '0;
		cycles_per_bit = 10'(bit_period);
		streams = '0;
		rxd = 1'b1;
		repeat (16) @(negedge clock);
		reset = 1'b0;
		check_reset_values();
		send_at_command();
		read_at_response();
		select_streams();
		overflow_stream();
		$display("NO ERRORS");
		$finish;
	end

endmodule

// File: bt_bridge.f
common/bt_types_pkg.sv
common/uart_pkg.sv
design/byte_fifo.sv
design/stream_switch.sv
bridge_ctrl/bridge_ctrl.sv
uart/uart_tx.sv
uart/uart_rx.sv
design/bt_bridge.sv
verif/bt_bridge_asserts.sv
verif/bt_bridge_tb.sv

// File: build.sh
#!/usr/bin/env bash
# Build the bridge testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module bt_bridge_tb \
	--Mdir obj_dir -o bt_bridge_sim \
	-f bt_bridge.f

status=0
./obj_dir/bt_bridge_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "ERRORS FOUND" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"
